// File: app_top.f
+incdir+include
hw/app_pkg.sv
hw/tick_divider.sv
hw/scratch_pad_regs.sv
hw/pulse_gen.sv
hw/gpio_regs.sv
hw/heartbeat_ctrl.sv
hw/opb_addr_decode.sv
hw/app_top.sv
test/tb_app_top.sv

// File: hw/app_pkg.sv
// Register bus types, address map and identity words
// Divider defaults for the 100 MHz build
`default_nettype none

package app_pkg;

    // ====================
    // Bus types
    // ====================
    localparam int DATA_W = 32;                     // Bus data width
    localparam int ADDR_W = 12;                     // Byte address width

    typedef struct packed {
        logic              re;                      // One-cycle read strobe
        logic              we;                      // One-cycle write strobe
        logic [ADDR_W-1:0] addr;                    // Page in bits 11:8
        logic [DATA_W-1:0] wdata;                   // Write data
    } opb_req_t;

    typedef struct packed {
        logic sp;                                   // Scratch pad page
        logic pulse;                                // Pulse generator page
        logic gpio;                                 // GPIO page
    } opb_sel_t;

    // ====================
    // Address map
    // ====================
    localparam logic [3:0] PAGE_SP    = 4'h0;
    localparam logic [3:0] PAGE_PULSE = 4'h1;
    localparam logic [3:0] PAGE_GPIO  = 4'h2;

    localparam logic [7:0] REG_VERSION    = 8'h00;  // Scratch pad page
    localparam logic [7:0] REG_ID         = 8'h04;
    localparam logic [7:0] REG_DATE       = 8'h08;
    localparam logic [7:0] REG_SCRATCH    = 8'h0C;
    localparam logic [7:0] REG_TICK_COUNT = 8'h00;  // Pulse page
    localparam logic [7:0] REG_TICK_CLEAR = 8'h04;
    localparam logic [7:0] REG_GPIO_IN    = 8'h00;  // GPIO page
    localparam logic [7:0] REG_GPIO_OUT   = 8'h04;
    localparam logic [7:0] REG_LED        = 8'h08;

    // ====================
    // Constants
    // ====================
    localparam logic [DATA_W-1:0] FW_VERSION    = 32'h0000_0001;
    localparam logic [DATA_W-1:0] FPGA_ID       = 32'h0000_0100;
    localparam logic [DATA_W-1:0] BUILD_DATE    = 32'h2025_0809; // YYYY_MMDD
    localparam logic [DATA_W-1:0] UNMAPPED_DATA = 32'hDEAD_BEEF; // Hole in the map

    localparam int GPIO_W            = 16;          // GPIO in/out width
    localparam int TICK_DIV_DEFAULT  = 50000;       // 2 kHz from 100 MHz
    localparam int BLINK_DIV_DEFAULT = 1000;        // Ref ticks per half blink

endpackage

`default_nettype wire

// File: hw/app_top.sv
// Application top level
// Bus decoder, three register slaves and the heartbeat LED logic
`default_nettype none

module app_top import app_pkg::*; #(
    parameter int tick_div  = TICK_DIV_DEFAULT,     // Clocks per reference tick
    parameter int blink_div = BLINK_DIV_DEFAULT     // Ref ticks per LED half-period
) (
    input  logic              opb_clk,
    input  logic              rst_n,
    input  opb_req_t          opb_req,              // From the bus master
    output logic [DATA_W-1:0] opb_rdata,            // Valid one cycle after re
    input  logic [GPIO_W-1:0] gpio_in,              // Asynchronous status pins
    output logic [GPIO_W-1:0] gpio_out,
    output logic              ref_pulse_out,        // Reference strobe
    output logic              heartbeat_led_n       // Active low
);

    opb_sel_t          sel;                         // Page selects
    logic [DATA_W-1:0] sp_rdata;
    logic [DATA_W-1:0] pulse_rdata;
    logic [DATA_W-1:0] gpio_rdata;
    logic              led_reg;                     // LED bit from GPIO page

    opb_addr_decode opb_addr_decode_inst (
        .opb_clk     (opb_clk),
        .rst_n       (rst_n),
        .opb_req     (opb_req),
        .sel         (sel),
        .sp_rdata    (sp_rdata),
        .pulse_rdata (pulse_rdata),
        .gpio_rdata  (gpio_rdata),
        .opb_rdata   (opb_rdata)
    );

    scratch_pad_regs scratch_pad_regs_inst (
        .opb_clk (opb_clk),
        .rst_n   (rst_n),
        .opb_req (opb_req),
        .sel_sp  (sel.sp),
        .rdata   (sp_rdata)
    );

    pulse_gen #(
        .tick_div (tick_div)
    ) pulse_gen_inst (
        .opb_clk   (opb_clk),
        .rst_n     (rst_n),
        .opb_req   (opb_req),
        .sel_pulse (sel.pulse),
        .ref_tick  (ref_pulse_out),                 // Also feeds the heartbeat
        .rdata     (pulse_rdata)
    );

    gpio_regs gpio_regs_inst (
        .opb_clk  (opb_clk),
        .rst_n    (rst_n),
        .opb_req  (opb_req),
        .sel_gpio (sel.gpio),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .led_reg  (led_reg),
        .rdata    (gpio_rdata)
    );

    heartbeat_ctrl #(
        .blink_div (blink_div)
    ) heartbeat_ctrl_inst (
        .opb_clk         (opb_clk),
        .rst_n           (rst_n),
        .opb_req         (opb_req),
        .ref_tick        (ref_pulse_out),
        .led_reg         (led_reg),
        .heartbeat_led_n (heartbeat_led_n)
    );

endmodule

`default_nettype wire

// File: hw/gpio_regs.sv
// GPIO page
// Two-flop input synchronizer, output word and heartbeat LED bit
`default_nettype none

module gpio_regs import app_pkg::*; (
    input  logic              opb_clk,
    input  logic              rst_n,
    input  opb_req_t          opb_req,
    input  logic              sel_gpio,
    input  logic [GPIO_W-1:0] gpio_in,              // Asynchronous pins
    output logic [GPIO_W-1:0] gpio_out,
    output logic              led_reg,              // Active low LED bit
    output logic [DATA_W-1:0] rdata
);

    logic [7:0]        offset;
    logic              wr_en;
    logic [GPIO_W-1:0] sync_q;                      // First synchronizer stage
    logic [GPIO_W-1:0] gpio_stat;                   // Second stage, status reg

    assign offset = opb_req.addr[7:0];
    assign wr_en  = sel_gpio && opb_req.we;

    // ====================
    // Input synchronizer
    // ====================
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q    <= '0;
            gpio_stat <= '0;
        end else begin
            sync_q    <= gpio_in;
            gpio_stat <= sync_q;
        end
    end

    // ====================
    // Writable registers
    // ====================
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            gpio_out <= '0;
            led_reg  <= 1'b1;                       // LED off
        end else if (wr_en) begin
            if (offset == REG_GPIO_OUT) begin
                gpio_out <= opb_req.wdata[GPIO_W-1:0];
            end
            if (offset == REG_LED) begin
                led_reg <= opb_req.wdata[0];
            end
        end
    end

    // Zero-extended read words
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (sel_gpio && opb_req.re) begin
            case (offset)
                REG_GPIO_IN:  rdata <= {{(DATA_W-GPIO_W){1'b0}}, gpio_stat};
                REG_GPIO_OUT: rdata <= {{(DATA_W-GPIO_W){1'b0}}, gpio_out};
                REG_LED:      rdata <= {{(DATA_W-1){1'b0}}, led_reg};
                default:      rdata <= UNMAPPED_DATA;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/heartbeat_ctrl.sv
// Heartbeat LED control
// Free-running blinker until the first bus access, then the LED register
`default_nettype none

module heartbeat_ctrl import app_pkg::*; #(
    parameter int blink_div = BLINK_DIV_DEFAULT     // Ref ticks per half-period
) (
    input  logic     opb_clk,
    input  logic     rst_n,
    input  opb_req_t opb_req,                       // Only re and we are watched
    input  logic     ref_tick,
    input  logic     led_reg,
    output logic     heartbeat_led_n
);

    logic blink_tick;                               // Held for one ref period
    logic blinker;
    logic woken;                                    // Bus has been used

    // Divider steps on each reference strobe edge
    tick_divider #(
        .div (blink_div)
    ) blink_div_inst (
        .opb_clk (ref_tick),
        .rst_n   (rst_n),
        .tick    (blink_tick)
    );

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            blinker <= 1'b1;                        // LED off
        end else if (ref_tick && blink_tick) begin
            blinker <= ~blinker;                    // Once per blink_div ticks
        end
    end

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            woken <= 1'b0;
        end else if (opb_req.re || opb_req.we) begin
            woken <= 1'b1;                          // Sticky until reset
        end
    end

    assign heartbeat_led_n = woken ? led_reg : blinker;

endmodule

`default_nettype wire

// File: hw/opb_addr_decode.sv
// Page decoder for the register bus
// Slave selects and the registered read-data mux
`default_nettype none

module opb_addr_decode import app_pkg::*; (
    input  logic              opb_clk,
    input  logic              rst_n,
    input  opb_req_t          opb_req,
    output opb_sel_t          sel,
    input  logic [DATA_W-1:0] sp_rdata,             // Registered slave words
    input  logic [DATA_W-1:0] pulse_rdata,
    input  logic [DATA_W-1:0] gpio_rdata,
    output logic [DATA_W-1:0] opb_rdata
);

    logic [3:0] page;                               // Current request page
    logic [3:0] rd_page;                            // Page of the last read

    assign page = opb_req.addr[11:8];

    always_comb begin
        sel.sp    = (page == PAGE_SP);
        sel.pulse = (page == PAGE_PULSE);
        sel.gpio  = (page == PAGE_GPIO);
    end

    // Remember which slave answers the last read
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_page <= PAGE_SP;                     // Slave words reset to 0
        end else if (opb_req.re) begin
            rd_page <= page;
        end
    end

    always_comb begin
        case (rd_page)
            PAGE_SP:    opb_rdata = sp_rdata;
            PAGE_PULSE: opb_rdata = pulse_rdata;
            PAGE_GPIO:  opb_rdata = gpio_rdata;
            default:    opb_rdata = UNMAPPED_DATA;  // Empty page
        endcase
    end

endmodule

`default_nettype wire

// File: hw/pulse_gen.sv
// Pulse generator page
// Reference tick strobe and a clearable 32-bit tick counter
`default_nettype none

module pulse_gen import app_pkg::*; #(
    parameter int tick_div = TICK_DIV_DEFAULT       // Clocks per reference tick
) (
    input  logic              opb_clk,
    input  logic              rst_n,
    input  opb_req_t          opb_req,
    input  logic              sel_pulse,
    output logic              ref_tick,             // One cycle every tick_div
    output logic [DATA_W-1:0] rdata
);

    logic [7:0]        offset;
    logic              clear;                       // Counter clear request
    logic [DATA_W-1:0] tick_count;

    assign offset = opb_req.addr[7:0];
    assign clear  = sel_pulse && opb_req.we && (offset == REG_TICK_CLEAR);

    tick_divider #(
        .div (tick_div)
    ) ref_div_inst (
        .opb_clk (opb_clk),
        .rst_n   (rst_n),
        .tick    (ref_tick)
    );

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_count <= '0;
        end else if (clear) begin
            tick_count <= '0;                       // Clear beats a tick
        end else if (ref_tick) begin
            tick_count <= tick_count + 1'b1;
        end
    end

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (sel_pulse && opb_req.re) begin
            if (offset == REG_TICK_COUNT) begin
                rdata <= tick_count;
            end else begin
                rdata <= UNMAPPED_DATA;             // Clear reg is write only
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/scratch_pad_regs.sv
// Scratch pad page
// Version, FPGA ID and build date words plus one read/write word
`default_nettype none

module scratch_pad_regs import app_pkg::*; (
    input  logic              opb_clk,
    input  logic              rst_n,
    input  opb_req_t          opb_req,
    input  logic              sel_sp,               // Page select from decoder
    output logic [DATA_W-1:0] rdata                 // Held until next read
);

    logic [7:0]        offset;
    logic [DATA_W-1:0] scratch;

    assign offset = opb_req.addr[7:0];

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            scratch <= '0;
        end else if (sel_sp && opb_req.we && offset == REG_SCRATCH) begin
            scratch <= opb_req.wdata;
        end
    end

    // Read word captured on the re edge
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (sel_sp && opb_req.re) begin
            case (offset)
                REG_VERSION: rdata <= FW_VERSION;
                REG_ID:      rdata <= FPGA_ID;
                REG_DATE:    rdata <= BUILD_DATE;
                REG_SCRATCH: rdata <= scratch;
                default:     rdata <= UNMAPPED_DATA;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/tick_divider.sv
// Down-counting strobe divider
// One-cycle tick every div clocks
`default_nettype none

module tick_divider #(
    parameter int div = 2                           // Period in clocks, 2 or more
) (
    input  logic opb_clk,
    input  logic rst_n,
    output logic tick                               // Registered strobe
);

    localparam int             CNT_W  = $clog2(div);
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(div - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= RELOAD;
            tick <= 1'b0;                           // Quiet out of reset
        end else begin
            tick <= (cnt == '0);
            if (cnt == '0) begin
                cnt <= RELOAD;                      // Wrap, next period
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: include/tb_opb_tasks.svh
// Bus master tasks for the testbench
// Reset wait with timeout, word write and read, error counters and checks
`ifndef TB_OPB_TASKS_SVH
`define TB_OPB_TASKS_SVH

int error_count   = 0;                              // Value mismatches
int timeout_count = 0;                              // Waits that ran out

function automatic void note_error(input string msg);
    error_count++;
    $display("ERROR %0t: %s", $time, msg);
endfunction

function automatic void note_timeout(input string msg);
    timeout_count++;
    $display("ERROR %0t: timed out, %s", $time, msg);
endfunction

function automatic void check_eq(input logic [app_pkg::DATA_W-1:0] got,
                                 input logic [app_pkg::DATA_W-1:0] exp,
                                 input string what);
    assert (got === exp)
    else note_error($sformatf("%s read %h, expected %h", what, got, exp));
endfunction

// Bus is only driven once reset has gone away
task automatic wait_reset_done(input int max_cycles = 1000);
    int n;
    n = 0;
    while (!rst_n && n < max_cycles) begin
        @(posedge opb_clk);
        n++;
    end
    if (!rst_n) note_timeout("reset was never released");
endtask

task automatic opb_write(input logic [app_pkg::ADDR_W-1:0] addr,
                         input logic [app_pkg::DATA_W-1:0] data);
    wait_reset_done();
    @(posedge opb_clk);
    opb_req.we    <= 1'b1;
    opb_req.addr  <= addr;
    opb_req.wdata <= data;
    @(posedge opb_clk);                             // Write lands here
    opb_req.we    <= 1'b0;
endtask

task automatic opb_read(input  logic [app_pkg::ADDR_W-1:0] addr,
                        output logic [app_pkg::DATA_W-1:0] data);
    wait_reset_done();
    @(posedge opb_clk);
    opb_req.re   <= 1'b1;
    opb_req.addr <= addr;
    @(posedge opb_clk);                             // Read sampled here
    opb_req.re   <= 1'b0;
    @(negedge opb_clk);                             // One cycle latency
    data = opb_rdata;
endtask

task automatic opb_check(input logic [app_pkg::ADDR_W-1:0] addr,
                         input logic [app_pkg::DATA_W-1:0] exp,
                         input string what);
    logic [app_pkg::DATA_W-1:0] got;
    opb_read(addr, got);
    check_eq(got, exp, what);
endtask

`endif

// File: test/tb_app_top.sv
// Testbench for the register bus core
// Bus master stimulus, reference tick model, checks and closing report
`default_nettype none

module tb_app_top import app_pkg::*; ();

    localparam int TICK_DIV  = 8;                   // Small ratios for simulation
    localparam int BLINK_DIV = 4;

    logic              opb_clk;
    logic              rst_n;
    opb_req_t          opb_req;
    logic [DATA_W-1:0] opb_rdata;
    logic [GPIO_W-1:0] gpio_in;
    logic [GPIO_W-1:0] gpio_out;
    logic              ref_pulse_out;
    logic              heartbeat_led_n;
    int                ref_ticks   = 0;             // Strobes seen at clock edges
    int                ticks_at_re = 0;             // ref_ticks at the last read edge

    `include "tb_opb_tasks.svh"

    app_top #(.tick_div(TICK_DIV), .blink_div(BLINK_DIV)) app_top_inst (.*);

    initial begin
        opb_clk = 1'b0;
        forever #2 opb_clk = ~opb_clk;
    end

    // Strobe counter sampled at the same edges as the DUT
    always @(posedge opb_clk) begin
        if (ref_pulse_out) ref_ticks <= ref_ticks + 1;
        if (opb_req.re) ticks_at_re <= ref_ticks;
    end

    // Count falling edges until the strobe reaches a level
    task automatic wait_ref_level(input logic level, input int max_cycles, output int cycles);
        cycles = 0;
        do begin
            @(negedge opb_clk);
            cycles++;
        end while (ref_pulse_out !== level && cycles < max_cycles);
        if (ref_pulse_out !== level) note_timeout("ref_pulse_out never reached the level");
    endtask

    initial begin
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] c1;
        logic [GPIO_W-1:0] gv;
        int                width;
        int                gap;
        int                t1;
        int                n;
        int                moved;
        logic              led0;
        void'($urandom(32'h23ab_01bc));
        rst_n   = 1'b0;
        opb_req = '0;
        gpio_in = '0;
        repeat (2) @(posedge opb_clk);
        rst_n <= 1'b1;
        @(negedge opb_clk);
        // ====================
        // Reset and blinking
        // ====================
        assert (gpio_out === '0) else note_error("gpio_out not zero after reset");
        wait_ref_level(1'b1, 4 * TICK_DIV, gap);
        wait_ref_level(1'b0, 4, width);
        wait_ref_level(1'b1, 4 * TICK_DIV, gap);
        assert (width == 1) else note_error($sformatf("ref pulse %0d cycles wide", width));
        assert (width + gap == TICK_DIV)
        else note_error($sformatf("ref period %0d cycles", width + gap));
        led0 = heartbeat_led_n;
        n    = 0;
        while (heartbeat_led_n === led0 && n < 4 * BLINK_DIV * TICK_DIV) begin
            @(negedge opb_clk);
            n++;
        end
        if (heartbeat_led_n === led0) note_timeout("heartbeat LED never toggled before wake-up");
        // ====================
        // Identity and scratch
        // ====================
        opb_check({PAGE_SP, REG_VERSION}, 32'h0000_0001, "version");
        opb_check({PAGE_SP, REG_ID}, 32'h0000_0100, "FPGA ID");
        opb_check({PAGE_SP, REG_DATE}, 32'h2025_0809, "build date");
        repeat (4) begin
            data = $urandom();
            opb_write({PAGE_SP, REG_SCRATCH}, data);
            opb_check({PAGE_SP, REG_SCRATCH}, data, "scratch");
        end
        // ====================
        // GPIO
        // ====================
        repeat (4) begin
            gv = GPIO_W'($urandom());
            @(posedge opb_clk);
            gpio_in <= gv;
            repeat (2) @(posedge opb_clk);            // Read issued 3 edges after the change
            opb_check({PAGE_GPIO, REG_GPIO_IN}, DATA_W'(gv), "gpio_in");
        end
        data = $urandom();
        opb_write({PAGE_GPIO, REG_GPIO_OUT}, data);
        @(negedge opb_clk);
        assert (gpio_out === data[GPIO_W-1:0])
        else note_error($sformatf("gpio_out %h, expected %h", gpio_out, data[GPIO_W-1:0]));
        opb_check({PAGE_GPIO, REG_GPIO_OUT}, DATA_W'(data[GPIO_W-1:0]), "gpio_out");
        // Tick counter against the strobe count
        opb_read({PAGE_PULSE, REG_TICK_COUNT}, c1);
        t1 = ticks_at_re;
        repeat (5 * TICK_DIV) @(posedge opb_clk);
        opb_read({PAGE_PULSE, REG_TICK_COUNT}, data);
        assert (ticks_at_re > t1) else note_error("no reference ticks between reads");
        check_eq(data - c1, DATA_W'(ticks_at_re - t1), "tick count delta");
        opb_write({PAGE_PULSE, REG_TICK_CLEAR}, '0);
        opb_read({PAGE_PULSE, REG_TICK_COUNT}, data);
        assert (data <= 1) else note_error($sformatf("tick count %h after clear", data));
        // LED follows the register after wake-up
        for (int v = 0; v < 2; v++) begin
            opb_write({PAGE_GPIO, REG_LED}, DATA_W'(v));
            moved = 0;
            repeat (3 * BLINK_DIV * TICK_DIV) begin
                @(negedge opb_clk);
                if (heartbeat_led_n !== v[0]) moved++;
            end
            assert (moved == 0) else note_error($sformatf("LED left register value %0d", v));
        end
        // Holes in the map
        opb_check({4'h3, 8'h00}, 32'hDEAD_BEEF, "unmapped page");
        opb_check({PAGE_GPIO, 8'h0C}, 32'hDEAD_BEEF, "unmapped GPIO offset");
        $display("Errors: %0d mismatches, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
